/* tb.f */
hw/soc_pkg.sv
hw/mem_bus_if.sv
hw/boot_rom.sv
hw/sram_bank.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/rst_dbg_ctrl.sv
hw/soc_harness_top.sv
test/tb_clk_gen.sv
test/soc_bus_checker.sv
test/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
  import soc_pkg::*;

  // all tests take roughly 300 cycles
  localparam int unsigned TIMEOUT_CYCLES = 3000;
  localparam int unsigned GNT_WAIT       = 16;
  localparam int unsigned SRAM_TEST      = 8;
  localparam int unsigned ARB_ACCESSES   = 4;
  // unmapped address used by the debug requester
  localparam logic [ADDR_W-1:0] HOLE_ADDR = 32'h4000_0000;

  logic              clk_i, rst_ni;
  logic              ndmreset_i, debug_req_i, debug_en_i, debug_req_o;
  logic              host_req_i, host_we_i, dbg_req_i, dbg_we_i;
  logic [ADDR_W-1:0] host_addr_i, dbg_addr_i;
  logic [DATA_W-1:0] host_wdata_i, dbg_wdata_i, host_rdata_o, dbg_rdata_o;
  logic [BE_W-1:0]   host_be_i, dbg_be_i;
  logic              host_gnt_o, host_rvalid_o, host_err_o;
  logic              dbg_gnt_o, dbg_rvalid_o, dbg_err_o;

  int unsigned       value_errs;
  int unsigned       other_errs;
  int unsigned       cycle_cnt;
  logic [15:0]       lfsr_q;
  // expected contents of the first sram words
  logic [DATA_W-1:0] sram_model [SRAM_TEST];

  tb_clk_gen u_tb_clk_gen (
    .clk_o  ( clk_i  ),
    .rst_no ( rst_ni )
  );

  soc_harness_top u_soc_harness_top (.*);

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  // taps of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] next_bits(input int unsigned n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  task automatic compare_word(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
    assert (got === exp) else begin
      $display("ERROR: %s = 0x%08h, expected 0x%08h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic note_failure(input string what);
    $display("%s", what);
    other_errs++;
  endtask

  // one host access, returns the response data
  task automatic host_access(input logic we, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [BE_W-1:0] be,
                             output logic [DATA_W-1:0] rdata, output logic err);
    int unsigned waited;
    waited = 0;
    @(posedge clk_i);
    host_req_i   <= 1'b1;
    host_we_i    <= we;
    host_addr_i  <= addr;
    host_wdata_i <= wdata;
    host_be_i    <= be;
    @(negedge clk_i);
    while (!host_gnt_o && waited < GNT_WAIT) begin
      @(negedge clk_i);
      waited++;
    end
    assert (host_gnt_o)
      else note_failure($sformatf("host access to 0x%08h was never granted", addr));
    @(posedge clk_i);
    host_req_i <= 1'b0;
    @(negedge clk_i);
    assert (host_rvalid_o)
      else note_failure($sformatf("no host response after grant for 0x%08h", addr));
    rdata = host_rdata_o;
    err   = host_err_o;
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_debug_gate();
    @(negedge clk_i);
    while (!rst_ni) @(negedge clk_i);
    for (int i = 0; i < DEBUG_DELAY; i++) begin
      compare_word("debug_req_o", DATA_W'(debug_req_o), '0);
      @(negedge clk_i);
    end
    compare_word("debug_req_o", DATA_W'(debug_req_o), 1);
    @(posedge clk_i);
    debug_en_i <= 1'b0;
    @(negedge clk_i);
    compare_word("debug_req_o", DATA_W'(debug_req_o), '0);
    @(posedge clk_i);
    debug_en_i  <= 1'b1;
    debug_req_i <= 1'b0;
    @(negedge clk_i);
    compare_word("debug_req_o", DATA_W'(debug_req_o), '0);
    @(posedge clk_i);
    debug_req_i <= 1'b1;
    @(negedge clk_i);
    compare_word("debug_req_o", DATA_W'(debug_req_o), 1);
  endtask

  task automatic test_rom();
    logic [DATA_W-1:0] rdata;
    logic              err;
    for (int k = 0; k < ROM_WORDS; k++) begin
      host_access(1'b0, ROM_BASE + ADDR_W'(4 * k), '0, '0, rdata, err);
      compare_word("host_rdata_o", rdata, {ROM_TAG, 16'(k)});
      compare_word("host_err_o", DATA_W'(err), '0);
    end
  endtask

  task automatic test_sram();
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic [BE_W-1:0]   be;
    logic              err;
    for (int i = 0; i < SRAM_TEST; i++) begin
      addr          = SRAM_BASE + ADDR_W'(4 * i);
      sram_model[i] = addr ^ 32'hA5A5_5A5A;
      host_access(1'b1, addr, sram_model[i], '1, rdata, err);
    end
    // partial writes merge into the known words
    for (int n = 0; n < 2 * SRAM_TEST; n++) begin
      addr  = SRAM_BASE + ADDR_W'(4 * (n % SRAM_TEST));
      wdata = next_bits(32);
      be    = BE_W'(next_bits(BE_W));
      host_access(1'b1, addr, wdata, be, rdata, err);
      for (int b = 0; b < BE_W; b++) begin
        if (be[b]) begin
          sram_model[n % SRAM_TEST][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end
    for (int i = 0; i < SRAM_TEST; i++) begin
      host_access(1'b0, SRAM_BASE + ADDR_W'(4 * i), '0, '0, rdata, err);
      compare_word("host_rdata_o", rdata, sram_model[i]);
      compare_word("host_err_o", DATA_W'(err), '0);
    end
  endtask

  task automatic test_err_target();
    logic [ADDR_W-1:0] holes [5];
    logic [DATA_W-1:0] rdata;
    logic              err;
    holes = '{32'h0000_0000, 32'h0000_1040, 32'h4000_0000, 32'h8000_0400, 32'hFFFF_FFFC};
    foreach (holes[i]) begin
      host_access(1'b0, holes[i], '0, '0, rdata, err);
      compare_word("host_rdata_o", rdata, ERR_WORD);
      compare_word("host_err_o", DATA_W'(err), 1);
    end
    // a write into a hole leaves nothing behind
    host_access(1'b1, 32'h4000_0000, 32'h1234_5678, '1, rdata, err);
    host_access(1'b0, 32'h4000_0000, '0, '0, rdata, err);
    compare_word("host_rdata_o", rdata, ERR_WORD);
    compare_word("host_err_o", DATA_W'(err), 1);
  endtask

  task automatic test_arbitration();
    logic [DATA_W-1:0] host_exp [$];
    logic [DATA_W-1:0] dbg_exp [$];
    int unsigned       h_idx, d_idx, h_seen, d_seen, cycles;
    logic              both, last_dbg, have_last;
    h_idx     = 0;
    d_idx     = 0;
    h_seen    = 0;
    d_seen    = 0;
    cycles    = 0;
    last_dbg  = 1'b0;
    have_last = 1'b0;
    @(posedge clk_i);
    host_req_i  <= 1'b1;
    host_we_i   <= 1'b0;
    host_addr_i <= ROM_BASE;
    dbg_req_i   <= 1'b1;
    dbg_we_i    <= 1'b0;
    dbg_addr_i  <= SRAM_BASE;
    while ((h_seen < ARB_ACCESSES || d_seen < ARB_ACCESSES) && cycles < 6 * ARB_ACCESSES) begin
      @(negedge clk_i);
      cycles++;
      both = host_req_i && dbg_req_i;
      assert (!(host_gnt_o && dbg_gnt_o)) else note_failure("both requesters granted at once");
      // host only reads rom here
      compare_word("host_err_o", DATA_W'(host_err_o), '0);
      // responses belong to the grants of the cycle before
      if (host_rvalid_o) begin
        assert (host_exp.size() > 0) else note_failure("host response without a host access");
        if (host_exp.size() > 0) begin
          compare_word("host_rdata_o", host_rdata_o, host_exp.pop_front());
        end
        h_seen++;
      end
      if (dbg_rvalid_o) begin
        assert (dbg_exp.size() > 0) else note_failure("debug response without a debug access");
        if (dbg_exp.size() > 0) begin
          compare_word("dbg_rdata_o", dbg_rdata_o, dbg_exp.pop_front());
        end
        // only the last debug access goes to a hole
        compare_word("dbg_err_o", DATA_W'(dbg_err_o), DATA_W'(d_seen == ARB_ACCESSES - 1));
        d_seen++;
      end
      if (host_gnt_o) begin
        if (both && have_last) begin
          assert (last_dbg) else note_failure("host won twice in a row under contention");
        end
        host_exp.push_back({ROM_TAG, 16'(h_idx)});
        h_idx++;
        last_dbg  = 1'b0;
        have_last = both;
      end
      if (dbg_gnt_o) begin
        if (both && have_last) begin
          assert (!last_dbg) else note_failure("debug won twice in a row under contention");
        end
        if (d_idx == ARB_ACCESSES - 1) begin
          dbg_exp.push_back(ERR_WORD);
        end else begin
          dbg_exp.push_back(sram_model[d_idx]);
        end
        d_idx++;
        last_dbg  = 1'b1;
        have_last = both;
      end
      @(posedge clk_i);
      host_req_i  <= (h_idx < ARB_ACCESSES);
      host_addr_i <= ROM_BASE + ADDR_W'(4 * h_idx);
      dbg_req_i   <= (d_idx < ARB_ACCESSES);
      dbg_addr_i  <= (d_idx == ARB_ACCESSES - 1) ? HOLE_ADDR : SRAM_BASE + ADDR_W'(4 * d_idx);
    end
    assert (h_seen == ARB_ACCESSES && d_seen == ARB_ACCESSES)
      else note_failure("arbitration test did not get every response back");
  endtask

  task automatic test_ndmreset();
    @(posedge clk_i);
    ndmreset_i  <= 1'b1;
    host_req_i  <= 1'b1;
    host_we_i   <= 1'b0;
    host_addr_i <= ROM_BASE + 32'h8;
    repeat (3) begin
      @(negedge clk_i);
      assert (!host_gnt_o && !dbg_gnt_o) else note_failure("grant during non-debug reset");
      compare_word("debug_req_o", DATA_W'(debug_req_o), '0);
    end
    @(posedge clk_i);
    ndmreset_i <= 1'b0;
    // bus stays in reset for two edges after release
    repeat (2) begin
      @(negedge clk_i);
      assert (!host_gnt_o) else note_failure("grant before bus reset was released");
    end
    @(negedge clk_i);
    assert (host_gnt_o) else note_failure("no grant two cycles after reset release");
    compare_word("debug_req_o", DATA_W'(debug_req_o), 1);
    @(posedge clk_i);
    host_req_i <= 1'b0;
    @(negedge clk_i);
    assert (host_rvalid_o) else note_failure("no response after reset release");
    compare_word("host_rdata_o", host_rdata_o, {ROM_TAG, 16'd2});
  endtask

  // ----------------------------------------
  // run control
  // ----------------------------------------
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", cycle_cnt);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    value_errs   = 0;
    other_errs   = 0;
    cycle_cnt    = 0;
    lfsr_q       = 16'd81;
    ndmreset_i   = 1'b0;
    debug_req_i  = 1'b1;
    debug_en_i   = 1'b1;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    host_be_i    = '0;
    dbg_req_i    = 1'b0;
    dbg_we_i     = 1'b0;
    dbg_addr_i   = '0;
    dbg_wdata_i  = '0;
    dbg_be_i     = '0;
    test_debug_gate();
    test_rom();
    test_sram();
    test_err_target();
    test_arbitration();
    test_ndmreset();
    $display("errors: value=%0d other=%0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* test/soc_bus_checker.sv */
`timescale 1ns/1ps

module soc_bus_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic host_req_i,
  input logic dbg_req_i,
  input logic host_gnt_i,
  input logic dbg_gnt_i,
  input logic rvalid_i,
  input logic err_i
);

  logic any_gnt;

  assign any_gnt = host_gnt_i | dbg_gnt_i;

  // one response exactly one cycle after each grant
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_gnt |=> rvalid_i)
    else $error("bus response missing one cycle after a grant");

  rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |-> $past(any_gnt))
    else $error("bus response without a grant in the cycle before");

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(host_gnt_i && !host_req_i) && !(dbg_gnt_i && !dbg_req_i))
    else $error("grant given to a requester that did not request");

  // bus stays silent while held in reset
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !(any_gnt || rvalid_i || err_i))
    else $error("bus activity while the bus is in reset");

endmodule

bind bus_arbiter soc_bus_checker u_soc_bus_checker (
  .clk_i      ( clk_i                        ),
  .rst_ni     ( rst_ni                       ),
  .host_req_i ( host_req_i                   ),
  .dbg_req_i  ( dbg_req_i                    ),
  .host_gnt_i ( host_gnt_o                   ),
  .dbg_gnt_i  ( dbg_gnt_o                    ),
  .rvalid_i   ( host_rvalid_o | dbg_rvalid_o ),
  .err_i      ( host_err_o | dbg_err_o       )
);

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset held for ten rising edges
  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* hw/soc_harness_top.sv */
`timescale 1ns/1ps

module soc_harness_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ndmreset_i,
  input  logic                       debug_req_i,
  input  logic                       debug_en_i,
  output logic                       debug_req_o,
  // host port
  input  logic                       host_req_i,
  input  logic                       host_we_i,
  input  logic [soc_pkg::ADDR_W-1:0] host_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] host_wdata_i,
  input  logic [soc_pkg::BE_W-1:0]   host_be_i,
  output logic                       host_gnt_o,
  output logic                       host_rvalid_o,
  output logic [soc_pkg::DATA_W-1:0] host_rdata_o,
  output logic                       host_err_o,
  // debug system bus port
  input  logic                       dbg_req_i,
  input  logic                       dbg_we_i,
  input  logic [soc_pkg::ADDR_W-1:0] dbg_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] dbg_wdata_i,
  input  logic [soc_pkg::BE_W-1:0]   dbg_be_i,
  output logic                       dbg_gnt_o,
  output logic                       dbg_rvalid_o,
  output logic [soc_pkg::DATA_W-1:0] dbg_rdata_o,
  output logic                       dbg_err_o
);

  logic bus_rst_n;

  mem_bus_if bus_if ();

  // ----------------------------------------
  // reset and debug gating
  // ----------------------------------------
  rst_dbg_ctrl u_rst_dbg_ctrl (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ndmreset_i  ( ndmreset_i  ),
    .debug_req_i ( debug_req_i ),
    .debug_en_i  ( debug_en_i  ),
    .bus_rst_no  ( bus_rst_n   ),
    .debug_req_o ( debug_req_o )
  );

  // ----------------------------------------
  // bus fabric
  // ----------------------------------------
  bus_arbiter u_bus_arbiter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( bus_rst_n     ),
    .host_req_i    ( host_req_i    ),
    .host_we_i     ( host_we_i     ),
    .host_addr_i   ( host_addr_i   ),
    .host_wdata_i  ( host_wdata_i  ),
    .host_be_i     ( host_be_i     ),
    .host_gnt_o    ( host_gnt_o    ),
    .host_rvalid_o ( host_rvalid_o ),
    .host_rdata_o  ( host_rdata_o  ),
    .host_err_o    ( host_err_o    ),
    .dbg_req_i     ( dbg_req_i     ),
    .dbg_we_i      ( dbg_we_i      ),
    .dbg_addr_i    ( dbg_addr_i    ),
    .dbg_wdata_i   ( dbg_wdata_i   ),
    .dbg_be_i      ( dbg_be_i      ),
    .dbg_gnt_o     ( dbg_gnt_o     ),
    .dbg_rvalid_o  ( dbg_rvalid_o  ),
    .dbg_rdata_o   ( dbg_rdata_o   ),
    .dbg_err_o     ( dbg_err_o     ),
    .bus_o         ( bus_if        )
  );

  bus_decoder u_bus_decoder (
    .clk_i  ( clk_i     ),
    .rst_ni ( bus_rst_n ),
    .bus_i  ( bus_if    )
  );

endmodule

/* hw/rst_dbg_ctrl.sv */
`timescale 1ns/1ps

module rst_dbg_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic bus_rst_no,
  output logic debug_req_o
);
  import soc_pkg::*;

  logic                 sync_rst_n;
  logic [1:0]           sync_q;
  logic [DBG_CNT_W-1:0] dly_cnt_q;

  // ----------------------------------------
  // bus reset synchroniser
  // ----------------------------------------
  // asserts at once, releases after two edges
  assign sync_rst_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge sync_rst_n) begin
    if (!sync_rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign bus_rst_no = sync_q[1];

  // ----------------------------------------
  // debug request hold-off
  // ----------------------------------------
  // reloaded by power-on reset only
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dly_cnt_q <= DBG_CNT_W'(DEBUG_DELAY);
    end else if (dly_cnt_q != '0) begin
      dly_cnt_q <= dly_cnt_q - 1'b1;
    end
  end

  // passes only once the window is over, enabled, and the bus is up
  assign debug_req_o = debug_req_i & debug_en_i & (dly_cnt_q == '0) & sync_q[1];

endmodule

/* hw/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
  input  logic       clk_i,
  input  logic       rst_ni,
  mem_bus_if.target  bus_i
);
  import soc_pkg::*;

  target_e            tgt_d;
  target_e            tgt_q;
  logic               rvalid_q;

  logic [ROM_AW-1:0]  rom_addr;
  logic [DATA_W-1:0]  rom_rdata;
  logic               sram_req;
  logic [SRAM_AW-1:0] sram_addr;
  logic [DATA_W-1:0]  sram_rdata;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  always_comb begin
    if (bus_i.addr >= ROM_BASE && bus_i.addr < ROM_END) begin
      tgt_d = TGT_ROM;
    end else if (bus_i.addr >= SRAM_BASE && bus_i.addr < SRAM_END) begin
      tgt_d = TGT_SRAM;
    end else begin
      tgt_d = TGT_ERR;
    end
  end

  // every target accepts at once
  assign bus_i.gnt = bus_i.req;

  assign rom_addr  = bus_i.addr[WORD_OFF +: ROM_AW];
  assign sram_addr = bus_i.addr[WORD_OFF +: SRAM_AW];
  // writes outside sram go nowhere
  assign sram_req  = bus_i.gnt && (tgt_d == TGT_SRAM);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      tgt_q    <= TGT_ERR;
    end else begin
      rvalid_q <= bus_i.gnt;
      if (bus_i.gnt) begin
        tgt_q <= tgt_d;
      end
    end
  end

  // ----------------------------------------
  // response mux
  // ----------------------------------------
  always_comb begin
    case (tgt_q)
      TGT_ROM:  bus_i.rdata = rom_rdata;
      TGT_SRAM: bus_i.rdata = sram_rdata;
      default:  bus_i.rdata = ERR_WORD;
    endcase
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.err    = rvalid_q && (tgt_q == TGT_ERR);

  boot_rom u_boot_rom (
    .clk_i   ( clk_i     ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

  sram_bank u_sram_bank (
    .clk_i   ( clk_i       ),
    .req_i   ( sram_req    ),
    .we_i    ( bus_i.we    ),
    .addr_i  ( sram_addr   ),
    .wdata_i ( bus_i.wdata ),
    .be_i    ( bus_i.be    ),
    .rdata_o ( sram_rdata  )
  );

endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // host requester
  input  logic                       host_req_i,
  input  logic                       host_we_i,
  input  logic [soc_pkg::ADDR_W-1:0] host_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] host_wdata_i,
  input  logic [soc_pkg::BE_W-1:0]   host_be_i,
  output logic                       host_gnt_o,
  output logic                       host_rvalid_o,
  output logic [soc_pkg::DATA_W-1:0] host_rdata_o,
  output logic                       host_err_o,
  // debug requester
  input  logic                       dbg_req_i,
  input  logic                       dbg_we_i,
  input  logic [soc_pkg::ADDR_W-1:0] dbg_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] dbg_wdata_i,
  input  logic [soc_pkg::BE_W-1:0]   dbg_be_i,
  output logic                       dbg_gnt_o,
  output logic                       dbg_rvalid_o,
  output logic [soc_pkg::DATA_W-1:0] dbg_rdata_o,
  output logic                       dbg_err_o,
  // shared bus
  mem_bus_if.requester               bus_o
);

  // round-robin pointer, set when debug has priority
  logic rr_q;
  // owner of the response coming back next cycle
  logic owner_q;
  logic pick_dbg;

  // debug wins when alone or when it holds the pointer
  assign pick_dbg = dbg_req_i & (~host_req_i | rr_q);

  // ----------------------------------------
  // request path
  // ----------------------------------------
  // nothing reaches the bus while it is held in reset
  assign bus_o.req   = (host_req_i | dbg_req_i) & rst_ni;
  assign bus_o.we    = pick_dbg ? dbg_we_i    : host_we_i;
  assign bus_o.addr  = pick_dbg ? dbg_addr_i  : host_addr_i;
  assign bus_o.wdata = pick_dbg ? dbg_wdata_i : host_wdata_i;
  assign bus_o.be    = pick_dbg ? dbg_be_i    : host_be_i;

  assign host_gnt_o = bus_o.gnt & ~pick_dbg;
  assign dbg_gnt_o  = bus_o.gnt & pick_dbg;

  // ----------------------------------------
  // response path
  // ----------------------------------------
  assign host_rvalid_o = bus_o.rvalid & ~owner_q;
  assign dbg_rvalid_o  = bus_o.rvalid & owner_q;
  assign host_rdata_o  = bus_o.rdata;
  assign dbg_rdata_o   = bus_o.rdata;
  assign host_err_o    = bus_o.err & ~owner_q;
  assign dbg_err_o     = bus_o.err & owner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q    <= 1'b0;
      owner_q <= 1'b0;
    end else if (bus_o.gnt) begin
      // priority swaps on every accepted access
      rr_q    <= ~rr_q;
      owner_q <= pick_dbg;
    end
  end

endmodule

/* hw/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [soc_pkg::SRAM_AW-1:0] addr_i,
  input  logic [soc_pkg::DATA_W-1:0]  wdata_i,
  input  logic [soc_pkg::BE_W-1:0]    be_i,
  output logic [soc_pkg::DATA_W-1:0]  rdata_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0] mem_q [SRAM_WORDS];

  // ----------------------------------------
  // single port access
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // only enabled byte lanes change
        for (int b = 0; b < BE_W; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

/* hw/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom (
  input  logic                       clk_i,
  input  logic [soc_pkg::ROM_AW-1:0] addr_i,
  output logic [soc_pkg::DATA_W-1:0] rdata_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0] rom_table [ROM_WORDS];

  // ----------------------------------------
  // table contents
  // ----------------------------------------
  // each word carries its own index
  for (genvar k = 0; k < ROM_WORDS; k++) begin : g_table
    assign rom_table[k] = rom_word(k);
  end

  // read address is sampled every cycle, data shows up one cycle later
  always_ff @(posedge clk_i) begin
    rdata_o <= rom_table[addr_i];
  end

endmodule

/* hw/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if ();
  import soc_pkg::*;

  // request side
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [BE_W-1:0]   be;

  // response side
  logic              gnt;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              err;

  modport requester (
    output req,
    output we,
    output addr,
    output wdata,
    output be,
    input  gnt,
    input  rvalid,
    input  rdata,
    input  err
  );

  modport target (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    input  be,
    output gnt,
    output rvalid,
    output rdata,
    output err
  );

endinterface

/* hw/soc_pkg.sv */
package soc_pkg;

  // ----------------------------------------
  // bus widths
  // ----------------------------------------
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned BE_W     = DATA_W / 8;
  // byte offset bits below the word index
  localparam int unsigned WORD_OFF = $clog2(BE_W);

  // ----------------------------------------
  // address map
  // ----------------------------------------
  localparam logic [ADDR_W-1:0] ROM_BASE   = 32'h0000_1000;
  localparam int unsigned       ROM_WORDS  = 16;
  localparam int unsigned       ROM_AW     = $clog2(ROM_WORDS);
  localparam logic [ADDR_W-1:0] ROM_END    = ROM_BASE + ADDR_W'(ROM_WORDS * BE_W);

  localparam logic [ADDR_W-1:0] SRAM_BASE  = 32'h8000_0000;
  localparam int unsigned       SRAM_WORDS = 256;
  localparam int unsigned       SRAM_AW    = $clog2(SRAM_WORDS);
  localparam logic [ADDR_W-1:0] SRAM_END   = SRAM_BASE + ADDR_W'(SRAM_WORDS * BE_W);

  // answer for anything outside the map
  localparam logic [DATA_W-1:0] ERR_WORD   = 32'hBADC_AB1E;

  // rom word k = tag in upper half, k in lower half
  localparam logic [15:0]       ROM_TAG    = 16'hB007;

  // debug halt request held off this many cycles after power-on reset
  localparam int unsigned       DEBUG_DELAY = 64;
  localparam int unsigned       DBG_CNT_W   = $clog2(DEBUG_DELAY + 1);

  typedef enum logic [1:0] {
    TGT_ROM  = 2'd0,
    TGT_SRAM = 2'd1,
    TGT_ERR  = 2'd2
  } target_e;

  function automatic logic [DATA_W-1:0] rom_word(input int unsigned idx);
    return {ROM_TAG, 16'(idx)};
  endfunction

endpackage
